/* design/memCycleDecode.sv */
/*
 * Decodes one microstep per accepted cycle (clken high, stall low).
 * A step offered during stall is not taken; upstream must hold it.
 */
`default_nettype none

module memCycleDecode
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  logic               stall,
   input  vmaPkg::microStepT  step,
   output vmaPkg::decodedT    decoded,
   output logic               decodedValid
);

   logic accept;
   logic cacheSweep;
   logic selPrevious;
   logic vmaLoad;
   logic cycleLoad;
   logic userBit;
   vmaPkg::cycleTypeE cycleSrc;

   // Only place where back-pressure is seen
   assign accept = clken & ~stall;

   // Cache clear and previous select share one field, so exclusive
   assign cacheSweep  = (step.mem.specSel == vmaPkg::specClrCache);
   assign selPrevious = (step.mem.specSel == vmaPkg::specPrevious);

   // VMA load: load-VMA cycle, area read with dispatch VMA, or sweep
   assign vmaLoad = (step.mem.memCycle & step.mem.loadVma) |
                    (step.mem.memCycle & step.mem.areaRead & step.drom.dromVma) |
                    cacheSweep;

   // Cycle fields load on a waited cycle or a conditional byte write
   assign cycleLoad = (step.mem.memCycle & step.mem.memWait) |
                      (step.mem.memCycle & step.mem.bWrite & step.drom.condFunc);

   // Context rule for the user bit
   assign userBit = (~step.mem.forceExec & step.flagUser & ~step.cpuExec) |
                    (step.mem.fetchCycle & step.flagUser) |
                    (step.prevEn & step.flagPcu) |
                    (selPrevious & step.flagPcu) |
                    step.mem.forceUser;

   // Area read wins over dpFunc, microcode last
   always_comb
   begin
      if (step.mem.areaRead)
         cycleSrc = vmaPkg::cycDrom;
      else if (step.mem.dpFunc)
         cycleSrc = vmaPkg::cycDp;
      else
         cycleSrc = vmaPkg::cycMicro;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         decodedValid <= 1'b0;
      else
         decodedValid <= accept;
   end

   // Payload, only meaningful with decodedValid
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         decoded.vmaLoad     <= vmaLoad;
         decoded.cycleLoad   <= cycleLoad;
         decoded.cacheSweep  <= cacheSweep;
         decoded.selPrevious <= selPrevious;
         decoded.cycleSrc    <= cycleSrc;
         decoded.user        <= userBit;
         decoded.step        <= step;
      end
   end

endmodule

`default_nettype wire

/* design/memRequestIssue.sv */
/*
 * Credit-based request port. Valid is a one-cycle pulse per request and
 * spends a credit at that edge. memCredit returns at most one per cycle.
 */
`default_nettype none
`include "vma_macros.svh"

module memRequestIssue
(
   input  logic             clk,
   input  logic             rst,
   input  logic             reqLoad,
   input  vmaPkg::vmaWordT  vmaReg,
   input  logic             memCredit,
   output vmaPkg::memReqT   memReq,
   output logic             stall
);

   logic [`CREDIT_WIDTH-1:0] credits;
   // Pending queue, q0 is the oldest
   vmaPkg::vmaWordT q0;
   vmaPkg::vmaWordT q1;
   logic [1:0] qCount;
   logic haveQ;
   logic send;
   logic pushQ;
   logic popQ;
   logic reqValid;
   vmaPkg::vmaWordT reqWord;

   assign haveQ = (qCount != 2'd0);
   // Oldest first, a fresh reqLoad bypasses an empty queue
   assign send  = (haveQ | reqLoad) & (credits != '0);
   assign popQ  = send & haveQ;
   assign pushQ = reqLoad & ~(send & ~haveQ);

   // No credits stops intake early, covers the two steps in flight
   assign stall = haveQ | (credits == '0);

   assign memReq.valid = reqValid;
   assign memReq.vma   = reqWord;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         credits  <= `CREDIT_WIDTH'(`MEM_CREDITS);
         qCount   <= 2'd0;
         reqValid <= 1'b0;
      end
      else
      begin
         reqValid <= send;
         case ({send, memCredit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         case ({pushQ, popQ})
            2'b10:   qCount <= qCount + 1'b1;
            2'b01:   qCount <= qCount - 1'b1;
            default: qCount <= qCount;
         endcase
      end
   end

   // Request word and queue entries
   always_ff @(posedge clk)
   begin
      if (send)
         reqWord <= haveQ ? q0 : vmaReg;
      case ({pushQ, popQ})
         2'b10:
         begin
            if (qCount == 2'd0)
               q0 <= vmaReg;
            else
               q1 <= vmaReg;
         end
         2'b01:
            q0 <= q1;
         2'b11:
         begin
            // Shift and append in one cycle
            if (qCount == 2'd1)
               q0 <= vmaReg;
            else
            begin
               q0 <= q1;
               q1 <= vmaReg;
            end
         end
         default:
            q0 <= q0;
      endcase
   end

endmodule

`default_nettype wire

/* design/vmaPkg.sv */
/*
 * Shared types of the VMA stage. Words are packed MSB first, so the
 * user flag sits in bit 35 as in the machine's bit 0 numbering.
 */
`default_nettype none
`include "vma_macros.svh"

package vmaPkg;

   // Special function field of the microword
   typedef enum logic [1:0]
   {
      specNone     = `SPEC_SEL_NONE,
      specClrCache = `SPEC_SEL_CLRCACHE,
      specPrevious = `SPEC_SEL_PREVIOUS
   } specSelE;

   // Where the memory cycle type comes from
   typedef enum logic [1:0]
   {
      cycMicro,
      cycDrom,
      cycDp
   } cycleTypeE;

   ////////////////////////////////////////////////////////////////////////////
   // Microstep inputs
   ////////////////////////////////////////////////////////////////////////////

   // Control-store memory fields
   typedef struct packed
   {
      logic memCycle;
      logic loadVma;
      logic areaRead;
      logic dpFunc;
      // Wait for memory, named to avoid the keyword
      logic memWait;
      logic bWrite;
      logic extAddr;
      logic forceExec;
      logic fetchCycle;
      logic physical;
      logic forceUser;
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
      logic cacheInh;
      specSelE specSel;
   } memFieldsT;

   // Dispatch ROM bits
   typedef struct packed
   {
      logic dromVma;
      logic condFunc;
      logic readCycle;
      logic wrTestCycle;
      logic writeCycle;
   } dromFieldsT;

   // VMA word, also the layout of the datapath word
   typedef struct packed
   {
      logic user;
      logic exec;
      logic fetch;
      logic phys;
      logic prev;
      logic io;
      logic wru;
      logic vect;
      logic ioByte;
      logic read;
      logic wrTest;
      logic write;
      logic cacheInh;
      // Extended section bit, top of the address
      logic extd;
      logic [`VMA_WORD_ADDR_WIDTH-1:0] addr;
   } vmaWordT;

   typedef struct packed
   {
      memFieldsT mem;
      dromFieldsT drom;
      vmaWordT dp;
      logic cpuExec;
      logic prevEn;
      logic flagUser;
      logic flagPcu;
   } microStepT;

   ////////////////////////////////////////////////////////////////////////////
   // Internal and output records
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed
   {
      logic vmaLoad;
      logic cycleLoad;
      logic cacheSweep;
      logic selPrevious;
      cycleTypeE cycleSrc;
      // Context user bit, ready for the microcode source
      logic user;
      microStepT step;
   } decodedT;

   typedef struct packed
   {
      logic valid;
      vmaWordT vma;
   } memReqT;

endpackage

`default_nettype wire

/* design/vmaRegister.sv */
/*
 * VMA register. Address and context flags load on vmaLoad, cycle bits on
 * cycleLoad; the two loads are independent and may come in one step.
 */
`default_nettype none

module vmaRegister
(
   input  logic             clk,
   input  logic             rst,
   input  vmaPkg::decodedT  decoded,
   input  logic             decodedValid,
   output vmaPkg::vmaWordT  vmaReg,
   output logic             reqLoad
);

   logic vmaEn;
   logic cycleEn;

   assign vmaEn   = decodedValid & decoded.vmaLoad;
   assign cycleEn = decodedValid & decoded.cycleLoad;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         vmaReg  <= '0;
         reqLoad <= 1'b0;
      end
      else
      begin
         // One pulse per cycle-field load, starts a request
         reqLoad <= cycleEn;

         ////////////////////////////////////////////////////////////////////////
         // Address and context flags
         ////////////////////////////////////////////////////////////////////////

         if (vmaEn)
         begin
            // Extended bit always from microcode, word address from dp
            vmaReg.extd <= decoded.step.mem.extAddr;
            vmaReg.addr <= decoded.step.dp.addr;
            if (decoded.step.mem.dpFunc)
            begin
               // Datapath supplies the whole flag set
               vmaReg.user   <= decoded.step.dp.user;
               vmaReg.exec   <= decoded.step.dp.exec;
               vmaReg.fetch  <= decoded.step.dp.fetch;
               vmaReg.phys   <= decoded.step.dp.phys;
               vmaReg.prev   <= decoded.step.dp.prev;
               vmaReg.io     <= decoded.step.dp.io;
               vmaReg.wru    <= decoded.step.dp.wru;
               vmaReg.vect   <= decoded.step.dp.vect;
               vmaReg.ioByte <= decoded.step.dp.ioByte;
            end
            else
            begin
               // Microcode context; exec only comes from dp
               vmaReg.user   <= decoded.user;
               vmaReg.exec   <= 1'b0;
               vmaReg.fetch  <= decoded.step.mem.fetchCycle;
               vmaReg.phys   <= decoded.step.mem.physical;
               vmaReg.prev   <= decoded.step.prevEn | decoded.selPrevious;
               // Never an I/O cycle from microcode
               vmaReg.io     <= 1'b0;
               vmaReg.wru    <= 1'b0;
               vmaReg.vect   <= 1'b0;
               vmaReg.ioByte <= 1'b0;
            end
         end

         ////////////////////////////////////////////////////////////////////////
         // Memory cycle type
         ////////////////////////////////////////////////////////////////////////

         if (cycleEn)
         begin
            case (decoded.cycleSrc)
               vmaPkg::cycDrom:
               begin
                  // Dispatch ROM has no cache inhibit
                  vmaReg.read     <= decoded.step.drom.readCycle;
                  vmaReg.wrTest   <= decoded.step.drom.wrTestCycle;
                  vmaReg.write    <= decoded.step.drom.writeCycle;
                  vmaReg.cacheInh <= 1'b0;
               end
               vmaPkg::cycDp:
               begin
                  vmaReg.read     <= decoded.step.dp.read;
                  vmaReg.wrTest   <= decoded.step.dp.wrTest;
                  vmaReg.write    <= decoded.step.dp.write;
                  vmaReg.cacheInh <= decoded.step.dp.cacheInh;
               end
               default:
               begin
                  vmaReg.read     <= decoded.step.mem.readCycle;
                  vmaReg.wrTest   <= decoded.step.mem.wrTestCycle;
                  vmaReg.write    <= decoded.step.mem.writeCycle;
                  vmaReg.cacheInh <= decoded.step.mem.cacheInh;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* design/vmaUnit.sv */
/*
 * VMA stage top. Three cycles from step acceptance to request valid
 * when a credit is free; stall feeds back to the decode only.
 */
`default_nettype none

module vmaUnit
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  vmaPkg::microStepT  step,
   input  logic               memCredit,
   output vmaPkg::vmaWordT    vmaReg,
   output vmaPkg::memReqT     memReq,
   output logic               stall
);

   vmaPkg::decodedT decoded;
   logic decodedValid;
   logic reqLoad;

   // Input side
   memCycleDecode decodeStage
   (
      .clk          (clk),
      .rst          (rst),
      .clken        (clken),
      .stall        (stall),
      .step         (step),
      .decoded      (decoded),
      .decodedValid (decodedValid)
   );

   // VMA register
   vmaRegister vmaStage
   (
      .clk          (clk),
      .rst          (rst),
      .decoded      (decoded),
      .decodedValid (decodedValid),
      .vmaReg       (vmaReg),
      .reqLoad      (reqLoad)
   );

   // Output side against memory credits
   memRequestIssue issueStage
   (
      .clk       (clk),
      .rst       (rst),
      .reqLoad   (reqLoad),
      .vmaReg    (vmaReg),
      .memCredit (memCredit),
      .memReq    (memReq),
      .stall     (stall)
   );

endmodule

`default_nettype wire

/* include/vma_macros.svh */
/*
 * Fixed word widths of the 36-bit VMA stage and the memory port credit depth.
 * MEM_CREDITS must stay within 1..7 so the 3-bit credit counter cannot wrap.
 */
`ifndef VMA_MACROS_SVH
`define VMA_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Word widths
////////////////////////////////////////////////////////////////////////////

// Datapath and VMA word
`define VMA_WIDTH 36

// Address field, extended section bit plus word address
`define VMA_ADDR_WIDTH 23

// Word address part below the extended section bit
`define VMA_WORD_ADDR_WIDTH (`VMA_ADDR_WIDTH - 1)

////////////////////////////////////////////////////////////////////////////
// Memory port flow control
////////////////////////////////////////////////////////////////////////////

// Requests the memory side accepts before it must return credits
`define MEM_CREDITS 2
`define CREDIT_WIDTH 3

// Special function select codes of the microword
`define SPEC_SEL_NONE 2'd0
`define SPEC_SEL_CLRCACHE 2'd1
`define SPEC_SEL_PREVIOUS 2'd2

`endif

/* run.sh */
#!/bin/sh
# Build and run the VMA stage testbench with Verilator.
# Result is decided from the simulation log.

LOG=sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
   -f src.f --top-module vmaUnitTb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VvmaUnitTb > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$LOG"
   echo "Simulation exited with an error status"
   exit 1
fi

cat "$LOG"
if grep -q "TEST RESULT: FAIL" "$LOG"; then
   exit 1
fi
exit 0

/* src.f */
+incdir+include
design/vmaPkg.sv
design/memCycleDecode.sv
design/vmaRegister.sv
design/memRequestIssue.sv
design/vmaUnit.sv
test/vmaUnit_properties.sv
test/vmaUnitChecker.sv
test/vmaUnitTb.sv

/* test/vmaUnitChecker.sv */
/*
 * Reference model of the VMA stage. Predicts vmaReg and the request
 * order from accepted steps; the bench keeps steps held during stall.
 */
`default_nettype none

module vmaUnitChecker
(
   input  logic               clk,
   input  logic               rst,
   input  logic               clken,
   input  logic               stall,
   input  vmaPkg::microStepT  step,
   input  vmaPkg::vmaWordT    vmaReg,
   input  vmaPkg::memReqT     memReq,
   output int                 valueErrors,
   output int                 otherErrors,
   output int                 pendingReqs,
   output int                 seenReqs
);
   timeunit 1ns;
   timeprecision 100ps;

   vmaPkg::vmaWordT expVma;
   vmaPkg::vmaWordT p1Vma;
   vmaPkg::vmaWordT p2Vma;
   logic p1Valid;
   logic p2Valid;
   logic anyAccepted;
   int edgeCount;
   vmaPkg::vmaWordT reqQ[$];
   // Acceptance edge of each expected request
   int stampQ[$];

   assign pendingReqs = reqQ.size();

   // Applies one accepted step to the expected VMA and returns its cycle load
   function automatic logic applyStep(input vmaPkg::microStepT s);
      logic vl;
      logic cl;
      logic selPrev;
      begin
         selPrev = (s.mem.specSel == vmaPkg::specPrevious);
         vl = (s.mem.memCycle & (s.mem.loadVma | (s.mem.areaRead & s.drom.dromVma))) |
              (s.mem.specSel == vmaPkg::specClrCache);
         cl = s.mem.memCycle & (s.mem.memWait | (s.mem.bWrite & s.drom.condFunc));
         if (vl)
         begin
            expVma.extd = s.mem.extAddr;
            expVma.addr = s.dp.addr;
            if (s.mem.dpFunc)
            begin
               {expVma.user, expVma.exec, expVma.fetch, expVma.phys, expVma.prev} =
                  {s.dp.user, s.dp.exec, s.dp.fetch, s.dp.phys, s.dp.prev};
               {expVma.io, expVma.wru, expVma.vect, expVma.ioByte} =
                  {s.dp.io, s.dp.wru, s.dp.vect, s.dp.ioByte};
            end
            else
            begin
               // Context rule for user
               expVma.user = (s.flagUser & !s.cpuExec & !s.mem.forceExec) |
                             (s.mem.fetchCycle & s.flagUser) |
                             ((s.prevEn | selPrev) & s.flagPcu) | s.mem.forceUser;
               expVma.exec = 1'b0;
               expVma.fetch = s.mem.fetchCycle;
               expVma.phys = s.mem.physical;
               expVma.prev = s.prevEn | selPrev;
               {expVma.io, expVma.wru, expVma.vect, expVma.ioByte} = 4'b0000;
            end
         end
         if (cl)
         begin
            if (s.mem.areaRead)
               {expVma.read, expVma.wrTest, expVma.write, expVma.cacheInh} =
                  {s.drom.readCycle, s.drom.wrTestCycle, s.drom.writeCycle, 1'b0};
            else if (s.mem.dpFunc)
               {expVma.read, expVma.wrTest, expVma.write, expVma.cacheInh} =
                  {s.dp.read, s.dp.wrTest, s.dp.write, s.dp.cacheInh};
            else
               {expVma.read, expVma.wrTest, expVma.write, expVma.cacheInh} =
                  {s.mem.readCycle, s.mem.wrTestCycle, s.mem.writeCycle, s.mem.cacheInh};
         end
         return cl;
      end
   endfunction

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         expVma = '0;
         p1Valid = 1'b0;
         p2Valid = 1'b0;
         anyAccepted = 1'b0;
         edgeCount = 0;
      end
      else
      begin
         edgeCount++;
         // Quiet port before the first step
         if (!anyAccepted && (vmaReg !== '0 || memReq.valid !== 1'b0 || stall !== 1'b0))
         begin
            $display("Port not idle before the first step at %0t", $time);
            otherErrors++;
         end
         if (p2Valid && vmaReg !== p2Vma)
         begin
            $display("FAILED %0t vmaReg expected %h actual %h", $time, p2Vma, vmaReg);
            valueErrors++;
         end
         if (memReq.valid)
         begin
            seenReqs++;
            if (reqQ.size() == 0)
            begin
               $display("Unexpected memory request at %0t", $time);
               otherErrors++;
            end
            else
            begin
               if (memReq.vma !== reqQ[0])
               begin
                  $display("FAILED %0t memReq.vma expected %h actual %h",
                           $time, reqQ[0], memReq.vma);
                  valueErrors++;
               end
               void'(reqQ.pop_front());
               void'(stampQ.pop_front());
            end
         end
         // A request past its issue slot is waiting and must hold the decode
         if (reqQ.size() != 0 && edgeCount - stampQ[0] >= 3 && stall !== 1'b1)
         begin
            $display("FAILED %0t stall expected 1 actual %b", $time, stall);
            valueErrors++;
         end
         p2Valid = p1Valid;
         p2Vma = p1Vma;
         p1Valid = 1'b0;
         if (clken && !stall)
         begin
            anyAccepted = 1'b1;
            if (applyStep(step))
            begin
               reqQ.push_back(expVma);
               stampQ.push_back(edgeCount);
            end
            p1Valid = 1'b1;
            p1Vma = expVma;
         end
      end
   end

   initial
   begin
      valueErrors = 0;
      otherErrors = 0;
      seenReqs = 0;
   end

   // Final count against the bench's own tally
   task automatic finalCheck(input int expectedReqs, output int lateErrors);
      begin
         lateErrors = 0;
         if (reqQ.size() != 0)
         begin
            $display("%0d requests never reached the memory port", reqQ.size());
            lateErrors++;
         end
         if (seenReqs != expectedReqs)
         begin
            $display("Request count %0d does not match the table's %0d",
                     seenReqs, expectedReqs);
            lateErrors++;
         end
      end
   endtask

endmodule

`default_nettype wire

/* test/vmaUnitTb.sv */
/*
 * Bench for the VMA stage. Steps come from a table and are held while
 * stall is high; dp words and credit delays come from an LCG.
 */
`default_nettype none

module vmaUnitTb;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NumRows = 16;
   localparam int CycleLimit = NumRows * 20 + 100;

   typedef struct
   {
      logic [16:0] mem;
      logic [4:0]  drom;
      // cpuExec, prevEn, flagUser, flagPcu
      logic [3:0]  ctx;
      bit          expReq;
      int          drought;
   } rowT;

   logic clk;
   logic rst;
   logic clken;
   logic memCredit;
   vmaPkg::microStepT step;
   vmaPkg::vmaWordT vmaReg;
   vmaPkg::memReqT memReq;
   logic stall;

   int valueErrors;
   int otherErrors;
   int pendingReqs;
   int seenReqs;
   int lateErrors;
   int totalErrors;
   int cycleCount;
   int droughtUntil;
   int owed;
   int waitCnt;
   int expectedReqs;
   logic [31:0] seed;
   logic [31:0] creditSeed;
   logic [63:0] randWord;
   rowT rows[NumRows];

   vmaUnit uut
   (
      .clk       (clk),
      .rst       (rst),
      .clken     (clken),
      .step      (step),
      .memCredit (memCredit),
      .vmaReg    (vmaReg),
      .memReq    (memReq),
      .stall     (stall)
   );

   vmaUnitChecker chk
   (
      .clk         (clk),
      .rst         (rst),
      .clken       (clken),
      .stall       (stall),
      .step        (step),
      .vmaReg      (vmaReg),
      .memReq      (memReq),
      .valueErrors (valueErrors),
      .otherErrors (otherErrors),
      .pendingReqs (pendingReqs),
      .seenReqs    (seenReqs)
   );

   bind memRequestIssue vmaUnit_properties props
   (
      .clk     (clk),
      .rst     (rst),
      .credits (credits),
      .valid   (memReq.valid),
      .stall   (stall)
   );

   // Separate generator state per user keeps the sequences fixed
   function automatic logic [31:0] nextRand(inout logic [31:0] state);
      state = state * 32'd1103515245 + 32'd12345;
      return state >> 8;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever
         #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Memory side credit return
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         memCredit <= 1'b0;
         owed = 0;
         waitCnt = 0;
      end
      else
      begin
         if (memReq.valid)
            owed++;
         memCredit <= 1'b0;
         if (cycleCount >= droughtUntil && owed > 0)
         begin
            if (waitCnt == 0)
            begin
               memCredit <= 1'b1;
               owed--;
               waitCnt = nextRand(creditSeed) % 4;
            end
            else
               waitCnt--;
         end
      end
   end

   // Watchdog
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= CycleLimit)
      begin
         $display("Timeout after %0d cycles, %0d requests still pending",
                  cycleCount, pendingReqs);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial
   begin
      seed = 32'h92d1;
      creditSeed = 32'h92d1;
      cycleCount = 0;
      droughtUntil = 0;
      rst = 1'b1;
      clken = 1'b0;
      memCredit = 1'b0;
      step = '0;
      // mem columns: mc lv ar df _ wt bw ea fe _ fc ph fu _ rd wt wr ci _ spec
      rows[0]  = '{17'b1101_1000_000_0000_00, 5'b00000, 4'b0000, 1, 0};
      rows[1]  = '{17'b1100_1000_100_1000_00, 5'b00000, 4'b1010, 1, 0};
      rows[2]  = '{17'b1100_1011_010_0011_00, 5'b00000, 4'b0010, 1, 0};
      rows[3]  = '{17'b1100_1000_000_0100_10, 5'b00000, 4'b0001, 1, 0};
      rows[4]  = '{17'b1110_1000_000_1111_00, 5'b10101, 4'b0000, 1, 0};
      rows[5]  = '{17'b0000_0000_000_0000_01, 5'b00000, 4'b0000, 0, 0};
      rows[6]  = '{17'b1100_0000_000_1000_00, 5'b00000, 4'b0010, 0, 0};
      rows[7]  = '{17'b1000_0100_000_0010_00, 5'b01000, 4'b0000, 1, 0};
      // Credit drought backs up requests and raises stall
      rows[8]  = '{17'b1101_1000_000_0000_00, 5'b00000, 4'b0000, 1, 40};
      rows[9]  = '{17'b1100_1010_100_1001_00, 5'b00000, 4'b0110, 1, 0};
      rows[10] = '{17'b1110_1000_001_0000_00, 5'b10011, 4'b0000, 1, 0};
      rows[11] = '{17'b1100_1000_010_0010_10, 5'b00000, 4'b1010, 1, 0};
      rows[12] = '{17'b1001_1000_000_0000_00, 5'b00000, 4'b0000, 1, 0};
      rows[13] = '{17'b1100_1000_000_1000_00, 5'b00000, 4'b0101, 1, 30};
      rows[14] = '{17'b0000_0000_000_0000_01, 5'b00000, 4'b0000, 0, 0};
      rows[15] = '{17'b1101_1000_000_0000_00, 5'b00000, 4'b0000, 1, 0};
      expectedReqs = 0;
      repeat (3)
         @(posedge clk);
      rst <= 1'b0;
      repeat (2)
         @(posedge clk);
      for (int i = 0; i < NumRows; i++)
      begin
         // Each generator call holds 24 useful bits
         randWord[63:32] = nextRand(seed);
         randWord[31:0] = nextRand(seed);
         clken <= 1'b1;
         step.mem <= rows[i].mem;
         step.drom <= rows[i].drom;
         step.dp <= {randWord[43:32], randWord[23:0]};
         {step.cpuExec, step.prevEn, step.flagUser, step.flagPcu} <= rows[i].ctx;
         if (rows[i].drought > 0)
            droughtUntil <= cycleCount + rows[i].drought;
         if (rows[i].expReq)
            expectedReqs++;
         // Hold the step until an edge without stall takes it
         @(posedge clk);
         while (stall)
            @(posedge clk);
      end
      clken <= 1'b0;
      // Let the pipeline and the credit queue drain
      repeat (4)
         @(posedge clk);
      while (pendingReqs != 0)
         @(posedge clk);
      repeat (3)
         @(posedge clk);
      @(negedge clk);
      chk.finalCheck(expectedReqs, lateErrors);
      totalErrors = valueErrors + otherErrors + lateErrors +
                    uut.issueStage.props.assertFails;
      $display("Errors: %0d value, %0d other, %0d assertion, %0d requests seen",
               valueErrors, otherErrors + lateErrors,
               uut.issueStage.props.assertFails, seenReqs);
      if (totalErrors == 0)
         $display("TEST RESULT: PASS");
      else
         $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* test/vmaUnit_properties.sv */
/*
 * Credit rules of the memory request port. Bound into memRequestIssue
 * and reads its internal credit counter.
 */
`default_nettype none
`include "vma_macros.svh"

module vmaUnit_properties
(
   input logic                     clk,
   input logic                     rst,
   input logic [`CREDIT_WIDTH-1:0] credits,
   input logic                     valid,
   input logic                     stall
);
   timeunit 1ns;
   timeprecision 100ps;

   int assertFails;

   initial
      assertFails = 0;

   // A request spends a credit that was there at the issuing edge
   validNeedsCredit: assert property (@(posedge clk) disable iff (rst)
      valid |-> $past(credits) != '0)
      else
      begin
         $error("request valid without a credit");
         assertFails++;
      end

   // Returned credits never exceed the port depth
   creditBound: assert property (@(posedge clk) disable iff (rst)
      credits <= `CREDIT_WIDTH'(`MEM_CREDITS))
      else
      begin
         $error("credit count above its maximum");
         assertFails++;
      end

   // Full credits and an empty queue right after reset
   stallAfterReset: assert property (@(posedge clk)
      $fell(rst) |-> !stall)
      else
      begin
         $error("stall high right after reset");
         assertFails++;
      end

endmodule

`default_nettype wire
